/* flist.f */
alu_pkg.sv
add32.sv
shifter.sv
alu.sv
alu_exec.sv
tb_clkgen.sv
alu_exec_chk.sv
alu_exec_tb.sv

/* Bender.yml */
package:
  name: alu_exec

sources:
  # Design
  - alu_pkg.sv
  - add32.sv
  - shifter.sv
  - alu.sv
  - alu_exec.sv

  # Testbench
  - target: test
    files:
      - tb_clkgen.sv
      - alu_exec_chk.sv
      - alu_exec_tb.sv

/* alu_exec_tb.sv */
module alu_exec_tb
        import alu_pkg::*;
();

        timeunit 1ns;
        timeprecision 100ps;

        localparam int clk_period_ns = 8;
        localparam int reset_cycles  = 8;

        // Operations issued by each test
        localparam int arith_ops   = 69;
        localparam int shift_ops   = 128;
        localparam int logic_ops   = 33;
        localparam int stream_ops  = 50;
        localparam int latency_ops = 2;
        localparam int total_ops   = arith_ops + shift_ops + logic_ops + stream_ops + latency_ops;
        localparam int watchdog_ns = (total_ops * 20 + 2 * reset_cycles) * clk_period_ns;

        logic                  clk;
        logic                  reset;
        logic [data_width-1:0] a;
        logic [data_width-1:0] b;
        logic                  cin;
        logic [op_width-1:0]   op;
        logic                  inv_a;
        logic                  inv_b;
        logic                  sign_op;
        logic                  in_valid;
        logic                  in_ready;
        logic [data_width-1:0] result;
        logic                  ofl;
        logic                  zero;
        logic                  neg;
        logic                  out_valid;
        logic                  out_ready;

        integer seed;

        // Request word {a, b, cin, op, inv_a, inv_b, sign_op}, 72 bits
        logic [71:0] req_q [$];
        // Expected response {ofl, zero, neg, result}
        logic [34:0] exp_q [$];

        tb_clkgen clkgen0 (.clk(clk));

        alu_exec dut0 (
                .clk       (clk),
                .reset     (reset),
                .a         (a),
                .b         (b),
                .cin       (cin),
                .op        (op),
                .inv_a     (inv_a),
                .inv_b     (inv_b),
                .sign_op   (sign_op),
                .in_valid  (in_valid),
                .in_ready  (in_ready),
                .result    (result),
                .ofl       (ofl),
                .zero      (zero),
                .neg       (neg),
                .out_valid (out_valid),
                .out_ready (out_ready)
        );

        // Reference model of one ALU operation
        function automatic logic [34:0] expected_response(input logic [71:0] req);
                logic [31:0] opa;
                logic [31:0] opb;
                logic [31:0] res;
                logic [32:0] sum;
                logic [63:0] dbl;
                logic [4:0]  amt;
                logic        ovf;
                opa = req[2] ? ~req[71:40] : req[71:40];
                opb = req[1] ? ~req[39:8] : req[39:8];
                sum = {1'b0, opa} + {1'b0, opb} + req[7];
                dbl = {opa, opa};
                amt = opb[4:0];
                ovf = 1'b0;
                case (req[6:3])
                        op_rot_l:  res = dbl[(63 - amt) -: 32];
                        op_shft_l: res = opa << amt;
                        op_rot_r:  res = dbl[(31 + amt) -: 32];
                        op_shft_r: res = opa >> amt;
                        op_add: begin
                                res = sum[31:0];
                                if (req[0])
                                        ovf = (opa[31] == opb[31]) && (sum[31] != opa[31]);
                                else
                                        ovf = sum[32];
                        end
                        op_or:   res = opa | opb;
                        op_xor:  res = opa ^ opb;
                        op_and:  res = opa & opb;
                        op_btr: begin
                                for (int i = 0; i < 32; i++)
                                        res[i] = opa[31-i];
                        end
                        // Raw B, inversion ignored
                        op_lbi:  res = req[39:8];
                        op_slbi: res = {opa[15:0], 16'h0000} | opb;
                        op_nop:  res = opa;
                        default: res = 32'h0;
                endcase
                return {ovf, res == 32'h0, req[0] & res[31], res};
        endfunction

        task automatic compare(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
                if (actual !== expected) begin
                        $display("ERR %s: expected %0h, actual %0h", name, expected, actual);
                        $display("TB FAILED");
                        $fatal(1, "value mismatch in %s", name);
                end
        endtask

        task automatic add_op(input logic [31:0] va, input logic [31:0] vb, input logic vcin,
                              input logic [3:0] vop, input logic via, input logic vib,
                              input logic vsign);
                req_q.push_back({va, vb, vcin, vop, via, vib, vsign});
        endtask

        // Present one request and wait until it is taken
        task automatic send(input logic [71:0] req);
                @(posedge clk);
                #1;
                a        = req[71:40];
                b        = req[39:8];
                cin      = req[7];
                op       = req[6:3];
                inv_a    = req[2];
                inv_b    = req[1];
                sign_op  = req[0];
                in_valid = 1'b1;
                forever begin
                        @(negedge clk);
                        if (in_ready)
                                break;
                end
                exp_q.push_back(expected_response(req));
        endtask

        task automatic receive(input string name, input int n, input bit toggle);
                int          got;
                logic [34:0] exp;
                logic [31:0] rnd;
                got = 0;
                while (got < n) begin
                        @(posedge clk);
                        #1;
                        if (toggle) begin
                                rnd       = $random(seed);
                                out_ready = rnd[0];
                        end else begin
                                out_ready = 1'b1;
                        end
                        @(negedge clk);
                        if (out_valid && out_ready) begin
                                if (exp_q.size() == 0) begin
                                        $display("%s: response arrived with no request pending",
                                                 name);
                                        $display("TB FAILED");
                                        $fatal(1, "unexpected response");
                                end
                                exp = exp_q.pop_front();
                                compare(name, exp, {ofl, zero, neg, result});
                                got++;
                        end
                end
        endtask

        task automatic expect_idle(input string name);
                @(negedge clk);
                compare({name, " idle"}, 0, out_valid);
        endtask

        // Issue everything in req_q while collecting responses in parallel
        task automatic run_batch(input string name, input bit toggle);
                int n;
                n = req_q.size();
                fork
                        begin
                                while (req_q.size() > 0)
                                        send(req_q.pop_front());
                                @(posedge clk);
                                #1;
                                in_valid = 1'b0;
                        end
                        receive(name, n, toggle);
                join
                expect_idle(name);
        endtask

        task automatic apply_reset();
                reset    = 1'b1;
                in_valid = 1'b0;
                repeat (reset_cycles) @(posedge clk);
                #1;
                reset = 1'b0;
        endtask

        task automatic verify_reset_state(input string name);
                @(negedge clk);
                compare({name, " out_valid"}, 0, out_valid);
                compare({name, " in_ready"}, 1, in_ready);
        endtask

        task automatic adder_cases();
                logic [31:0] ra;
                logic [31:0] rb;
                // Signed overflow both ways, carry out, zero sum, subtract
                add_op(32'h7fff_ffff, 32'h0000_0001, 1'b0, op_add, 1'b0, 1'b0, 1'b1);
                add_op(32'h8000_0000, 32'hffff_ffff, 1'b0, op_add, 1'b0, 1'b0, 1'b1);
                add_op(32'hffff_ffff, 32'h0000_0001, 1'b0, op_add, 1'b0, 1'b0, 1'b0);
                add_op(32'h0000_0005, 32'hffff_fffb, 1'b0, op_add, 1'b0, 1'b0, 1'b1);
                add_op(32'h0000_000a, 32'h0000_0003, 1'b1, op_add, 1'b0, 1'b1, 1'b1);
                for (int v = 0; v < 4; v++) begin
                        for (int c = 0; c < 2; c++) begin
                                for (int s = 0; s < 2; s++) begin
                                        repeat (4) begin
                                                ra = $random(seed);
                                                rb = $random(seed);
                                                add_op(ra, rb, c[0], op_add, v[1], v[0], s[0]);
                                        end
                                end
                        end
                end
                run_batch("arith", 1'b0);
        endtask

        task automatic shift_sweep();
                logic [31:0] ra;
                logic [31:0] rb;
                for (int m = 0; m < 4; m++) begin
                        for (int c = 0; c < 32; c++) begin
                                ra = $random(seed);
                                rb = $random(seed);
                                // Upper bits of B are noise, only the low five count
                                add_op(ra, {rb[31:5], c[4:0]}, 1'b0, {2'b00, m[1:0]},
                                       1'b0, 1'b0, rb[0]);
                        end
                end
                run_batch("shifts", 1'b0);
        endtask

        task automatic logic_and_moves();
                logic [3:0]  codes [0:6] = '{op_or, op_xor, op_and, op_btr, op_lbi,
                                             op_slbi, op_nop};
                logic [31:0] ra;
                logic [31:0] rb;
                for (int i = 0; i < 7; i++) begin
                        for (int v = 0; v < 4; v++) begin
                                ra = $random(seed);
                                rb = $random(seed);
                                add_op(ra, rb, rb[3], codes[i], v[1], v[0], ra[0]);
                        end
                end
                // Adder carries out here, yet ofl must stay low
                add_op(32'hffff_ffff, 32'h0000_0001, 1'b1, op_or, 1'b0, 1'b0, 1'b0);
                for (int u = 11; u <= 14; u++) begin
                        ra = $random(seed);
                        rb = $random(seed);
                        add_op(ra, rb, 1'b1, u[3:0], 1'b0, 1'b0, 1'b1);
                end
                run_batch("logic", 1'b0);
        endtask

        task automatic stream_with_stalls();
                logic [31:0] ra;
                logic [31:0] rb;
                logic [31:0] ctl;
                for (int i = 0; i < stream_ops; i++) begin
                        ra  = $random(seed);
                        rb  = $random(seed);
                        ctl = $random(seed);
                        add_op(ra, rb, ctl[0], ctl[7:4], ctl[1], ctl[2], ctl[3]);
                end
                run_batch("handshake", 1'b1);
        endtask

        task automatic latency_and_reset();
                logic [34:0] exp;
                @(posedge clk);
                #1;
                out_ready = 1'b1;
                @(negedge clk);
                compare("latency idle", 0, out_valid);
                send({32'h0000_1234, 32'h0000_4321, 1'b0, op_add, 3'b001});
                @(posedge clk);
                #1;
                in_valid = 1'b0;
                // One edge after acceptance
                @(negedge clk);
                compare("latency out_valid", 1, out_valid);
                exp = exp_q.pop_front();
                compare("latency response", exp, {ofl, zero, neg, result});
                @(negedge clk);
                compare("latency drained", 0, out_valid);

                // Item stuck in the slice when reset arrives
                @(posedge clk);
                #1;
                out_ready = 1'b0;
                send({32'h0000_00ff, 32'h0000_0f00, 1'b0, op_or, 3'b000});
                @(posedge clk);
                #1;
                in_valid = 1'b0;
                @(negedge clk);
                compare("backpressure out_valid", 1, out_valid);
                compare("backpressure in_ready", 0, in_ready);
                exp_q.delete();
                @(posedge clk);
                #1;
                apply_reset();
                verify_reset_state("reset during hold");
        endtask

        initial begin
                #(watchdog_ns);
                $display("Timeout: tests did not finish within %0d ns", watchdog_ns);
                $display("TB FAILED");
                $fatal(1, "watchdog expired");
        end

        initial begin
                seed      = 32'h1a8b_7acc;
                reset     = 1'b1;
                a         = '0;
                b         = '0;
                cin       = 1'b0;
                op        = op_nop;
                inv_a     = 1'b0;
                inv_b     = 1'b0;
                sign_op   = 1'b0;
                in_valid  = 1'b0;
                out_ready = 1'b0;
                apply_reset();
                verify_reset_state("initial reset");
                adder_cases();
                shift_sweep();
                logic_and_moves();
                stream_with_stalls();
                latency_and_reset();
                repeat (2) @(posedge clk);
                if (dut0.chk0.assert_fails == 0) begin
                        $display("TB PASSED");
                        $finish;
                end else begin
                        $display("%0d assertion failures were reported",
                                 dut0.chk0.assert_fails);
                        $display("TB FAILED");
                        $fatal(1, "assertion failures");
                end
        end

endmodule

/* alu_exec_chk.sv */
module alu_exec_chk
        import alu_pkg::*;
(
        input logic                  clk,
        input logic                  reset,
        input logic                  in_valid,
        input logic                  in_ready,
        input logic                  out_valid,
        input logic                  out_ready,
        input logic [data_width-1:0] result
);

        timeunit 1ns;
        timeprecision 100ps;

        // Count of failed properties, read by the testbench at the end
        int assert_fails = 0;

        // Slice is empty right after a reset edge
        a_reset_clears: assert property (@(posedge clk) reset |=> !out_valid)
                else begin
                        $error("out_valid high in the cycle after reset");
                        assert_fails++;
                end

        // Held response under back-pressure
        a_hold_stable: assert property (@(posedge clk) disable iff (reset)
                        out_valid && !out_ready |=> out_valid && $stable(result))
                else begin
                        $error("response changed or dropped while out_ready was low");
                        assert_fails++;
                end

        // Accepted request sits in the slice one edge later
        a_accept_loads: assert property (@(posedge clk) disable iff (reset)
                        in_valid && in_ready |=> out_valid)
                else begin
                        $error("accepted request did not reach the output slice");
                        assert_fails++;
                end

endmodule

bind alu_exec alu_exec_chk chk0 (
        .clk       (clk),
        .reset     (reset),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .result    (result)
);

/* tb_clkgen.sv */
module tb_clkgen (
        output logic clk
);

        timeunit 1ns;
        timeprecision 100ps;

        // 8 ns period
        initial begin
                clk = 1'b0;
        end

        always #4 clk = ~clk;

endmodule

/* alu_exec.sv */
module alu_exec
        import alu_pkg::*;
(
        input  logic                  clk,
        input  logic                  reset,

        input  logic [data_width-1:0] a,
        input  logic [data_width-1:0] b,
        input  logic                  cin,
        input  logic [op_width-1:0]   op,
        input  logic                  inv_a,
        input  logic                  inv_b,
        input  logic                  sign_op,
        input  logic                  in_valid,
        output logic                  in_ready,

        output logic [data_width-1:0] result,
        output logic                  ofl,
        output logic                  zero,
        output logic                  neg,
        output logic                  out_valid,
        input  logic                  out_ready
);

        logic [data_width-1:0] alu_result;
        logic                  alu_ofl;
        logic                  alu_zero;
        logic                  alu_neg;
        logic                  accept;

        // Output slice: flags packed as {ofl, zero, neg}
        logic [data_width-1:0] result_q;
        logic [flag_count-1:0] flags_q;

        alu alu0 (
                .a       (a),
                .b       (b),
                .cin     (cin),
                .op      (op),
                .inv_a   (inv_a),
                .inv_b   (inv_b),
                .sign_op (sign_op),
                .result  (alu_result),
                .ofl     (alu_ofl),
                .zero    (alu_zero),
                .neg     (alu_neg)
        );

        // Slice can take a new item if empty or draining this cycle
        assign in_ready = !out_valid || out_ready;
        assign accept   = in_valid && in_ready;

        always_ff @(posedge clk) begin
                if (reset) begin
                        out_valid <= 1'b0;
                end else if (in_ready) begin
                        out_valid <= in_valid;
                end
        end

        always_ff @(posedge clk) begin
                if (accept) begin
                        result_q <= alu_result;
                        flags_q  <= {alu_ofl, alu_zero, alu_neg};
                end
        end

        assign result = result_q;
        assign ofl    = flags_q[2];
        assign zero   = flags_q[1];
        assign neg    = flags_q[0];

endmodule

/* alu.sv */
module alu
        import alu_pkg::*;
(
        input  logic [data_width-1:0] a,
        input  logic [data_width-1:0] b,
        input  logic                  cin,
        input  logic [op_width-1:0]   op,
        input  logic                  inv_a,
        input  logic                  inv_b,
        input  logic                  sign_op,
        output logic [data_width-1:0] result,
        output logic                  ofl,
        output logic                  zero,
        output logic                  neg
);

        // Operands after optional inversion
        logic [data_width-1:0] in_a;
        logic [data_width-1:0] in_b;

        logic [data_width-1:0] adder_out;
        logic                  adder_cout;
        logic [data_width-1:0] shftr_out;
        logic [data_width-1:0] btr_out;
        logic [data_width-1:0] slbi_out;
        logic                  ofl_raw;

        assign in_a = inv_a ? ~a : a;
        assign in_b = inv_b ? ~b : b;

        add32 adder (
                .a    (in_a),
                .b    (in_b),
                .cin  (cin),
                .sum  (adder_out),
                .cout (adder_cout)
        );

        // Count is the low bits of B, mode the low opcode bits
        shifter shftr (
                .din  (in_a),
                .cnt  (in_b[shamt_width-1:0]),
                .mode (op[1:0]),
                .dout (shftr_out)
        );

        // Bit reverse, msb swaps with lsb
        for (genvar i = 0; i < data_width; i++) begin : g_btr
                assign btr_out[i] = in_a[data_width-1-i];
        end

        // Upper half comes from A, B is ORed into the whole word
        assign slbi_out = (in_a << (data_width / 2)) | in_b;

        always_comb begin
                case (op)
                        op_rot_l,
                        op_shft_l,
                        op_rot_r,
                        op_shft_r: result = shftr_out;
                        op_add:    result = adder_out;
                        op_or:     result = in_a | in_b;
                        op_xor:    result = in_a ^ in_b;
                        op_and:    result = in_a & in_b;
                        op_btr:    result = btr_out;
                        // Immediate load takes B as given, inv_b has no effect
                        op_lbi:    result = b;
                        op_slbi:   result = slbi_out;
                        op_nop:    result = in_a;
                        default:   result = '0;
                endcase
        end

        // Signed overflow: operands agree in sign and the sum does not
        always_comb begin
                if (sign_op) begin
                        ofl_raw = (in_a[data_width-1] == in_b[data_width-1]) &&
                                  (adder_out[data_width-1] != in_a[data_width-1]);
                end else begin
                        // Unsigned case is just the carry out
                        ofl_raw = adder_cout;
                end
        end

        // Overflow means something only for ADD
        assign ofl  = (op == op_add) ? ofl_raw : 1'b0;
        assign zero = (result == '0);
        assign neg  = sign_op & result[data_width-1];

endmodule

/* shifter.sv */
module shifter
        import alu_pkg::*;
(
        input  logic [data_width-1:0]  din,
        input  logic [shamt_width-1:0] cnt,
        input  logic [1:0]             mode,
        output logic [data_width-1:0]  dout
);

        // One step of the barrel, by a fixed power-of-two distance
        function automatic logic [data_width-1:0] shift_step(
                input logic [data_width-1:0] x,
                input int                    amt,
                input logic [1:0]            mode_sel
        );
                logic [data_width-1:0] y;
                case (mode_sel)
                        op_rot_l[1:0]: begin
                                y = (x << amt) | (x >> (data_width - amt));
                        end
                        op_shft_l[1:0]: begin
                                y = x << amt;
                        end
                        op_rot_r[1:0]: begin
                                y = (x >> amt) | (x << (data_width - amt));
                        end
                        default: begin
                                // Logical right, zero fill
                                y = x >> amt;
                        end
                endcase
                return y;
        endfunction

        // stage[0] is the input, stage[shamt_width] the result
        logic [data_width-1:0] stage [0:shamt_width];

        assign stage[0] = din;

        // Count bit n moves the word by 2**n positions
        for (genvar lvl = 0; lvl < shamt_width; lvl++) begin : g_level
                assign stage[lvl+1] = cnt[lvl] ? shift_step(stage[lvl], 1 << lvl, mode)
                                               : stage[lvl];
        end

        assign dout = stage[shamt_width];

endmodule

/* add32.sv */
module add32
        import alu_pkg::*;
(
        input  logic [data_width-1:0] a,
        input  logic [data_width-1:0] b,
        input  logic                  cin,
        output logic [data_width-1:0] sum,
        output logic                  cout
);

        // Bit generate and propagate
        logic [data_width-1:0] g;
        logic [data_width-1:0] p;

        // Carry into each bit
        logic [data_width-1:0] c;

        // Group generate, propagate and carry in
        logic [cla_groups-1:0] grp_g;
        logic [cla_groups-1:0] grp_p;
        logic [cla_groups:0]   grp_c;

        assign g = a & b;
        assign p = a ^ b;

        // First level: fold each 4-bit group into one G/P pair
        always_comb begin
                int idx;
                for (int gi = 0; gi < cla_groups; gi++) begin
                        grp_g[gi] = 1'b0;
                        grp_p[gi] = 1'b1;
                        for (int k = 0; k < cla_group; k++) begin
                                idx = gi * cla_group + k;
                                grp_g[gi] = g[idx] | (p[idx] & grp_g[gi]);
                                grp_p[gi] = grp_p[gi] & p[idx];
                        end
                end
        end

        // Second level, written out as a sum of products per group carry
        always_comb begin
                logic term;
                grp_c[0] = cin;
                for (int i = 1; i <= cla_groups; i++) begin
                        grp_c[i] = cin;
                        for (int j = 0; j < i; j++) begin
                                grp_c[i] = grp_c[i] & grp_p[j];
                        end
                        for (int j = 0; j < i; j++) begin
                                term = grp_g[j];
                                for (int k = j + 1; k < i; k++) begin
                                        term = term & grp_p[k];
                                end
                                grp_c[i] = grp_c[i] | term;
                        end
                end
        end

        // Carries inside each group start from that group's carry in
        always_comb begin
                int idx;
                for (int gi = 0; gi < cla_groups; gi++) begin
                        c[gi * cla_group] = grp_c[gi];
                        for (int k = 1; k < cla_group; k++) begin
                                idx = gi * cla_group + k;
                                c[idx] = g[idx-1] | (p[idx-1] & c[idx-1]);
                        end
                end
        end

        assign sum  = p ^ c;
        assign cout = grp_c[cla_groups];

endmodule

/* alu_pkg.sv */
package alu_pkg;

        // Data path
        localparam int data_width  = 32;
        localparam int shamt_width = 5;
        localparam int op_width    = 4;

        // Result flags carried with each response: ofl, zero, neg
        localparam int flag_count  = 3;

        // Adder lookahead grouping
        localparam int cla_group   = 4;
        localparam int cla_groups  = data_width / cla_group;

        // Shift and rotate
        // The shifter decodes only bits [1:0], so these four must keep 00 on top
        localparam logic [op_width-1:0] op_rot_l  = 4'b0000;
        localparam logic [op_width-1:0] op_shft_l = 4'b0001;
        localparam logic [op_width-1:0] op_rot_r  = 4'b0010;
        localparam logic [op_width-1:0] op_shft_r = 4'b0011;

        // Arithmetic and logic
        localparam logic [op_width-1:0] op_add    = 4'b0100;
        localparam logic [op_width-1:0] op_or     = 4'b0101;
        localparam logic [op_width-1:0] op_xor    = 4'b0110;
        localparam logic [op_width-1:0] op_and    = 4'b0111;

        // Bit reverse and immediate loads
        localparam logic [op_width-1:0] op_btr    = 4'b1000;
        localparam logic [op_width-1:0] op_lbi    = 4'b1001;
        localparam logic [op_width-1:0] op_slbi   = 4'b1010;

        // Pass operand A through
        localparam logic [op_width-1:0] op_nop    = 4'b1111;

        // 1011 through 1110 are unused and give a zero result

endpackage
